// File: logic/rv_settings.svh
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// data path and address width
`define RV_XLEN 32

// first fetch address after reset
`define RV_RESET_PC 32'h8000_0000

// architectural integer registers, x0 included
`define RV_NUM_REGS 32

// fixed 32-bit encodings only, no compressed set
`define RV_ILEN 32

`endif

// File: logic/rv_isa_pkg.sv
`default_nettype none

`include "rv_settings.svh"

package rv_isa_pkg;

  // major opcodes, inst[6:0]
  typedef enum logic [6:0] {
    OP_IMM = 7'b001_0011,
    OP     = 7'b011_0011,
    LUI    = 7'b011_0111,
    AUIPC  = 7'b001_0111,
    JAL    = 7'b110_1111,
    JALR   = 7'b110_0111,
    BRANCH = 7'b110_0011,
    LOAD   = 7'b000_0011,
    STORE  = 7'b010_0011,
    SYSTEM = 7'b111_0011
  } opcode_e;

  // funct3 of conditional branches
  typedef enum logic [2:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } branch_f3_e;

  // funct3 of loads and stores, the _U forms are load only
  typedef enum logic [2:0] {
    BYTE   = 3'b000,
    HALF   = 3'b001,
    WORD   = 3'b010,
    BYTE_U = 3'b100,
    HALF_U = 3'b101
  } mem_f3_e;

  typedef logic [`RV_ILEN-1:0] inst_t;

endpackage

`default_nettype wire

// File: logic/rv_core_pkg.sv
`default_nettype none

`include "rv_settings.svh"

package rv_core_pkg;

  // adder operand a
  typedef enum logic [1:0] {
    OP_A_RS1  = 2'd0,
    OP_A_PC   = 2'd1,
    OP_A_ZERO = 2'd2  // lui
  } op_a_sel_e;

  // register write-back source
  typedef enum logic [1:0] {
    WB_ALU  = 2'd0,
    WB_LINK = 2'd1,  // pc + 4 for jal/jalr
    WB_LOAD = 2'd2
  } wb_sel_e;

  // all zero means a no-op
  typedef struct packed {
    op_a_sel_e              op_a_sel;
    logic                   op_b_imm;  // imm instead of rs2
    logic                   sub;
    logic                   reg_we;
    wb_sel_e                wb_sel;
    logic                   mem_rd;
    logic                   mem_wr;
    rv_isa_pkg::mem_f3_e    mem_size;
    logic                   is_branch;
    logic                   is_jump;
    rv_isa_pkg::branch_f3_e branch_op;
    logic                   halt;      // ebreak
  } ctrl_t;

  typedef struct packed {
    logic                rd;
    logic                wr;
    logic [`RV_XLEN-1:0] addr;   // word aligned
    logic [`RV_XLEN-1:0] wdata;  // lanes replicated
    logic [3:0]          wmask;
  } dmem_req_t;

endpackage

`default_nettype wire

// File: logic/rv_decoder.sv
`default_nettype none
`timescale 1ns/1ps

`include "rv_settings.svh"

module rv_decoder (
  input  rv_isa_pkg::inst_t   inst,
  output rv_core_pkg::ctrl_t  ctrl,
  output logic [`RV_XLEN-1:0] imm,
  output logic [4:0]          rs1_addr,
  output logic [4:0]          rs2_addr,
  output logic [4:0]          rd_addr
);

  rv_isa_pkg::opcode_e opcode;
  logic [2:0]          funct3;
  logic [6:0]          funct7;
  logic [31:0]         imm_i, imm_s, imm_b, imm_u, imm_j;

  assign opcode   = rv_isa_pkg::opcode_e'(inst[6:0]);
  assign funct3   = inst[14:12];
  assign funct7   = inst[31:25];
  assign rd_addr  = inst[11:7];
  assign rs1_addr = inst[19:15];
  assign rs2_addr = inst[24:20];

  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {inst[31:12], 12'h000};
  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    ctrl = '0;  // rs1 / alu / no strobes
    imm  = '0;
    case (opcode)
      rv_isa_pkg::OP_IMM: if (funct3 == 3'b000) begin  // addi only
        ctrl.op_b_imm = 1'b1;
        ctrl.reg_we   = 1'b1;
        imm           = imm_i;
      end
      rv_isa_pkg::OP: if (funct3 == 3'b000 && {funct7[6], funct7[4:0]} == 6'd0) begin
        ctrl.sub    = funct7[5];  // add vs sub
        ctrl.reg_we = 1'b1;
      end
      rv_isa_pkg::LUI, rv_isa_pkg::AUIPC: begin
        ctrl.op_a_sel = (opcode == rv_isa_pkg::LUI) ? rv_core_pkg::OP_A_ZERO
                                                    : rv_core_pkg::OP_A_PC;
        ctrl.op_b_imm = 1'b1;
        ctrl.reg_we   = 1'b1;
        imm           = imm_u;
      end
      rv_isa_pkg::JAL, rv_isa_pkg::JALR: begin
        // jal target is pc + imm, jalr goes through the adder
        ctrl.op_a_sel = (opcode == rv_isa_pkg::JAL) ? rv_core_pkg::OP_A_PC
                                                    : rv_core_pkg::OP_A_RS1;
        ctrl.op_b_imm = 1'b1;
        ctrl.reg_we   = 1'b1;
        ctrl.wb_sel   = rv_core_pkg::WB_LINK;
        ctrl.is_jump  = 1'b1;
        imm           = (opcode == rv_isa_pkg::JAL) ? imm_j : imm_i;
      end
      rv_isa_pkg::BRANCH: if (funct3[2:1] != 2'b01) begin
        ctrl.is_branch = 1'b1;
        ctrl.branch_op = rv_isa_pkg::branch_f3_e'(funct3);
        imm            = imm_b;
      end
      rv_isa_pkg::LOAD: if (funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101}) begin
        ctrl.op_b_imm = 1'b1;
        ctrl.reg_we   = 1'b1;
        ctrl.wb_sel   = rv_core_pkg::WB_LOAD;
        ctrl.mem_rd   = 1'b1;
        ctrl.mem_size = rv_isa_pkg::mem_f3_e'(funct3);
        imm           = imm_i;
      end
      rv_isa_pkg::STORE: if (funct3 inside {3'b000, 3'b001, 3'b010}) begin
        ctrl.op_b_imm = 1'b1;
        ctrl.mem_wr   = 1'b1;
        ctrl.mem_size = rv_isa_pkg::mem_f3_e'(funct3);
        imm           = imm_s;
      end
      rv_isa_pkg::SYSTEM: ctrl.halt = (inst[31:7] == 25'h0002000);  // ebreak, ecall ignored
      default: ;  // undecoded, retires as a no-op
    endcase
  end

  always_comb begin
    if (ctrl.mem_rd || ctrl.mem_wr) begin
      rd_wr_excl: assert final (!(ctrl.mem_rd && ctrl.mem_wr))
        else $error("decoder raised both load and store");
    end
  end

endmodule

`default_nettype wire

// File: logic/rv_regfile.sv
`default_nettype none
`timescale 1ns/1ps

`include "rv_settings.svh"

module rv_regfile (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                we,
  input  logic [4:0]          waddr,
  input  logic [`RV_XLEN-1:0] wdata,
  input  logic [4:0]          rs1_addr,
  input  logic [4:0]          rs2_addr,
  output logic [`RV_XLEN-1:0] rs1_data,
  output logic [`RV_XLEN-1:0] rs2_data
);

  logic [`RV_XLEN-1:0] regs [`RV_NUM_REGS];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `RV_NUM_REGS; i++) regs[i] <= '0;
    end else if (we && waddr != 5'd0) begin  // x0 stays zero
      regs[waddr] <= wdata;
    end
  end

  // reads see the value from before the edge
  assign rs1_data = regs[rs1_addr];
  assign rs2_data = regs[rs2_addr];

  x0_zero: assert property (@(posedge clk) disable iff (!rst_n)
    (rs1_addr == 5'd0 |-> rs1_data == '0) and (rs2_addr == 5'd0 |-> rs2_data == '0))
    else $error("x0 read back nonzero");

endmodule

`default_nettype wire

// File: logic/rv_execute.sv
`default_nettype none
`timescale 1ns/1ps

`include "rv_settings.svh"

module rv_execute (
  input  rv_core_pkg::ctrl_t  ctrl,
  input  logic [`RV_XLEN-1:0] pc,
  input  logic [`RV_XLEN-1:0] rs1_data,
  input  logic [`RV_XLEN-1:0] rs2_data,
  input  logic [`RV_XLEN-1:0] imm,
  output logic [`RV_XLEN-1:0] alu_out,
  output logic [`RV_XLEN-1:0] next_pc
);

  logic [`RV_XLEN-1:0] op_a;
  logic [`RV_XLEN-1:0] op_b;
  logic [`RV_XLEN-1:0] pc_imm;
  logic                eq, lt, ltu;
  logic                taken;

  always_comb begin
    case (ctrl.op_a_sel)
      rv_core_pkg::OP_A_PC:   op_a = pc;
      rv_core_pkg::OP_A_ZERO: op_a = '0;
      default:                op_a = rs1_data;
    endcase
  end

  assign op_b    = ctrl.op_b_imm ? imm : rs2_data;
  assign alu_out = ctrl.sub ? op_a - op_b : op_a + op_b;  // also the load/store address

  // branch compare on the register pair, not the adder
  assign eq  = (rs1_data == rs2_data);
  assign lt  = ($signed(rs1_data) < $signed(rs2_data));
  assign ltu = (rs1_data < rs2_data);

  always_comb begin
    case (ctrl.branch_op)
      rv_isa_pkg::BEQ:  taken = eq;
      rv_isa_pkg::BNE:  taken = !eq;
      rv_isa_pkg::BLT:  taken = lt;
      rv_isa_pkg::BGE:  taken = !lt;
      rv_isa_pkg::BLTU: taken = ltu;
      rv_isa_pkg::BGEU: taken = !ltu;
      default:          taken = 1'b0;
    endcase
  end

  assign pc_imm = pc + imm;

  always_comb begin
    if (ctrl.is_jump && ctrl.op_a_sel == rv_core_pkg::OP_A_RS1)
      next_pc = {alu_out[`RV_XLEN-1:1], 1'b0};  // jalr
    else if (ctrl.is_jump || (ctrl.is_branch && taken))
      next_pc = pc_imm;
    else
      next_pc = pc + `RV_XLEN'd4;
  end

endmodule

`default_nettype wire

// File: logic/rv_lsu.sv
`default_nettype none
`timescale 1ns/1ps

`include "rv_settings.svh"

module rv_lsu (
  input  rv_core_pkg::ctrl_t     ctrl,
  input  logic [`RV_XLEN-1:0]    addr,
  input  logic [`RV_XLEN-1:0]    store_data,
  input  logic [`RV_XLEN-1:0]    dmem_rdata,
  output rv_core_pkg::dmem_req_t req,
  output logic [`RV_XLEN-1:0]    load_data
);

  logic [1:0]  ofs;
  logic [7:0]  lane_b;
  logic [15:0] lane_h;

  assign ofs = addr[1:0];

  always_comb begin
    req      = '0;
    req.rd   = ctrl.mem_rd;
    req.wr   = ctrl.mem_wr;
    req.addr = {addr[`RV_XLEN-1:2], 2'b00};
    case (ctrl.mem_size)
      rv_isa_pkg::BYTE, rv_isa_pkg::BYTE_U: begin
        req.wmask = 4'b0001 << ofs;
        req.wdata = {4{store_data[7:0]}};
      end
      rv_isa_pkg::HALF, rv_isa_pkg::HALF_U: begin
        req.wmask = ofs[1] ? 4'b1100 : 4'b0011;  // upper or lower half
        req.wdata = {2{store_data[15:0]}};
      end
      default: begin
        req.wmask = 4'b1111;
        req.wdata = store_data;
      end
    endcase
    if (!ctrl.mem_wr) req.wmask = 4'b0000;  // mask only with a store
  end

  // lane pick from the aligned word
  assign lane_b = dmem_rdata[{ofs, 3'b000} +: 8];
  assign lane_h = dmem_rdata[{ofs[1], 4'b0000} +: 16];

  always_comb begin
    case (ctrl.mem_size)
      rv_isa_pkg::BYTE:   load_data = {{(`RV_XLEN-8){lane_b[7]}}, lane_b};
      rv_isa_pkg::BYTE_U: load_data = {{(`RV_XLEN-8){1'b0}}, lane_b};
      rv_isa_pkg::HALF:   load_data = {{(`RV_XLEN-16){lane_h[15]}}, lane_h};
      rv_isa_pkg::HALF_U: load_data = {{(`RV_XLEN-16){1'b0}}, lane_h};
      default:            load_data = dmem_rdata;
    endcase
  end

  always_comb begin
    if (ctrl.mem_rd || ctrl.mem_wr) begin
      aligned: assert final (
        (!(ctrl.mem_size inside {rv_isa_pkg::HALF, rv_isa_pkg::HALF_U}) || !ofs[0]) &&
        (ctrl.mem_size != rv_isa_pkg::WORD || ofs == 2'b00))
        else $error("misaligned access at %h", addr);
    end
  end

endmodule

`default_nettype wire

// File: logic/rv_core_top.sv
`default_nettype none
`timescale 1ns/1ps

`include "rv_settings.svh"

module rv_core_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  rv_isa_pkg::inst_t      imem_data,
  input  logic [`RV_XLEN-1:0]    dmem_rdata,
  output logic [`RV_XLEN-1:0]    imem_addr,
  output rv_core_pkg::dmem_req_t dmem_req,
  output logic                   halted
);

  rv_core_pkg::ctrl_t     ctrl;
  rv_core_pkg::dmem_req_t lsu_req;
  logic [`RV_XLEN-1:0]    pc, next_pc, pc_plus4;
  logic [`RV_XLEN-1:0]    imm, rs1_data, rs2_data, alu_out, load_data, wb_data;
  logic [4:0]             rs1_addr, rs2_addr, rd_addr;
  logic                   run;

  assign run       = rst_n && !halted;  // no side effects in reset or after ebreak
  assign imem_addr = pc;
  assign pc_plus4  = pc + `RV_XLEN'd4;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc     <= `RV_RESET_PC;
      halted <= 1'b0;
    end else if (run) begin
      pc     <= ctrl.halt ? pc : next_pc;  // park on the ebreak
      halted <= ctrl.halt;
    end
  end

  rv_decoder u_decoder (.inst(imem_data), .ctrl(ctrl), .imm(imm),
                        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr), .rd_addr(rd_addr));

  rv_regfile u_regfile (.clk(clk), .rst_n(rst_n), .we(ctrl.reg_we && run),
                        .waddr(rd_addr), .wdata(wb_data), .rs1_addr(rs1_addr),
                        .rs2_addr(rs2_addr), .rs1_data(rs1_data), .rs2_data(rs2_data));

  rv_execute u_execute (.ctrl(ctrl), .pc(pc), .rs1_data(rs1_data), .rs2_data(rs2_data),
                        .imm(imm), .alu_out(alu_out), .next_pc(next_pc));

  rv_lsu u_lsu (.ctrl(ctrl), .addr(alu_out), .store_data(rs2_data),
                .dmem_rdata(dmem_rdata), .req(lsu_req), .load_data(load_data));

  always_comb begin
    case (ctrl.wb_sel)
      rv_core_pkg::WB_LINK: wb_data = pc_plus4;
      rv_core_pkg::WB_LOAD: wb_data = load_data;
      default:              wb_data = alu_out;
    endcase
  end

  always_comb begin
    dmem_req       = lsu_req;
    dmem_req.rd    = lsu_req.rd && run;
    dmem_req.wr    = lsu_req.wr && run;
    dmem_req.wmask = lsu_req.wmask & {4{run}};
  end

endmodule

`default_nettype wire

// File: dv/tb_rv_program.svh
`ifndef TB_RV_PROGRAM_SVH
`define TB_RV_PROGRAM_SVH

// fills imem, expect_tbl, res_owner and lane_mask
task automatic build_program();
  logic [7:0]  b;
  logic [15:0] h;
  logic [31:0] w, pc_a;
  for (int i = 0; i < 256; i++) imem[i] = 32'h0010_0073;  // ebreak fill, runaway pc halts
  section = 2;
  emit(i_type(100, 5'd0, 3'b000, 5'd5, 7'h13));  // addi x5, x0, 100
  emit(i_type(-7, 5'd0, 3'b000, 5'd6, 7'h13));   // addi x6, x0, -7
  load_const(5'd1, DBASE);
  emit(r_type(7'h00, 5'd6, 5'd5, 3'b000, 5'd7));  // add x7, x5, x6
  emit(r_type(7'h20, 5'd6, 5'd5, 3'b000, 5'd8));  // sub x8, x5, x6
  emit(r_type(7'h20, 5'd5, 5'd6, 3'b000, 5'd9));  // sub x9, x6, x5
  emit(u_type(32'habcde, 5'd10, 7'h37));          // lui
  pc_a = `RV_RESET_PC + 4 * pi;
  emit(u_type(32'h00001, 5'd11, 7'h17));          // auipc
  store_result(5'd5, 32'd100);
  store_result(5'd6, 32'hffff_fff9);
  store_result(5'd7, 32'd93);
  store_result(5'd8, 32'd107);
  store_result(5'd9, 32'hffff_ff95);
  store_result(5'd10, 32'habcd_e000);
  store_result(5'd11, pc_a + 32'h1000);
  section = 3;
  load_const(5'd20, POISON);
  emit(i_type(100, 5'd0, 3'b000, 5'd12, 7'h13));  // x12 equals x5
  branch_case(3'b000, 5'd5, 5'd12, 1'b1);  // beq
  branch_case(3'b000, 5'd5, 5'd6, 1'b0);
  branch_case(3'b001, 5'd5, 5'd6, 1'b1);   // bne
  branch_case(3'b001, 5'd5, 5'd12, 1'b0);
  branch_case(3'b100, 5'd6, 5'd5, 1'b1);   // blt, -7 < 100
  branch_case(3'b100, 5'd5, 5'd6, 1'b0);
  branch_case(3'b101, 5'd5, 5'd6, 1'b1);   // bge
  branch_case(3'b101, 5'd6, 5'd5, 1'b0);
  branch_case(3'b110, 5'd5, 5'd6, 1'b1);   // bltu, -7 is huge unsigned
  branch_case(3'b110, 5'd6, 5'd5, 1'b0);
  branch_case(3'b111, 5'd6, 5'd5, 1'b1);   // bgeu
  branch_case(3'b111, 5'd5, 5'd6, 1'b0);
  pc_a = `RV_RESET_PC + 4 * pi;
  emit(j_type(8, 5'd13));  // jal x13, +8
  poison_store();
  store_result(5'd13, pc_a + 4);
  pc_a = `RV_RESET_PC + 4 * pi;
  emit(u_type(32'h0, 5'd14, 7'h17));              // auipc x14, 0
  emit(i_type(13, 5'd14, 3'b000, 5'd15, 7'h67));  // jalr x15, 13(x14), odd target
  poison_store();
  store_result(5'd15, pc_a + 8);
  section = 4;
  for (int o = 0; o < 4; o++) begin
    b = fill_byte(DBASE + o);
    emit(i_type(o, 5'd1, 3'b000, 5'd16, 7'h03));  // lb
    store_result(5'd16, {{24{b[7]}}, b});
    emit(i_type(o, 5'd1, 3'b100, 5'd16, 7'h03));  // lbu
    store_result(5'd16, {24'h0, b});
  end
  for (int o = 0; o < 4; o += 2) begin
    h = {fill_byte(DBASE + o + 1), fill_byte(DBASE + o)};
    emit(i_type(o, 5'd1, 3'b001, 5'd16, 7'h03));  // lh
    store_result(5'd16, {{16{h[15]}}, h});
    emit(i_type(o, 5'd1, 3'b101, 5'd16, 7'h03));  // lhu
    store_result(5'd16, {16'h0, h});
  end
  for (int o = 0; o < 8; o += 4) begin
    emit(i_type(o, 5'd1, 3'b010, 5'd16, 7'h03));  // lw
    store_result(5'd16, word_at(DBASE + o));
  end
  section = 5;
  load_const(5'd18, ST_VAL);
  for (int k = 0; k < 6; k++) begin
    if (k < 4) begin
      emit(s_type(32'h40 + 5 * k, 5'd18, 5'd1, 3'b000));  // sb, lane k of scratch word k
      lane_mask[k] = 4'b0001 << k;
    end else begin
      emit(s_type(32'h40 + 4 * k + 2 * (k - 4), 5'd18, 5'd1, 3'b001));  // sh
      lane_mask[k] = (k == 4) ? 4'b0011 : 4'b1100;
    end
  end
  for (int k = 0; k < 6; k++) begin
    w = word_at(DBASE + 32'h40 + 4 * k);
    if (k < 4)
      w[8 * k +: 8] = ST_VAL[7:0];
    else
      w[16 * (k - 4) +: 16] = ST_VAL[15:0];
    emit(i_type(32'h40 + 4 * k, 5'd1, 3'b010, 5'd16, 7'h03));  // lw merged word
    store_result(5'd16, w);
  end
  emit(32'h0010_0073);  // ebreak
endtask

`endif

// File: dv/tb_rv_core.sv
`default_nettype none
`timescale 1ns/1ps

`include "rv_settings.svh"

module tb_rv_core;

  localparam logic [31:0] DBASE    = 32'h0001_0000;
  localparam logic [31:0] RES_BASE = DBASE + 32'h100;
  localparam logic [31:0] POISON   = 32'hdead_beef;
  localparam logic [31:0] ST_VAL   = 32'ha5f3_c6e9;

  logic                   clk;
  logic                   rst_n;
  rv_isa_pkg::inst_t      imem_data;
  logic [31:0]            dmem_rdata;
  logic [31:0]            imem_addr;
  rv_core_pkg::dmem_req_t dmem_req;
  logic                   halted;

  logic [31:0] imem [0:255];
  logic [7:0]  dmem [0:1023];
  logic [31:0] expect_tbl [0:63];
  int          res_owner [0:63];  // behavior each result word belongs to
  bit          seen [0:63];
  logic [3:0]  lane_mask [0:5];
  int          pi, n_res, section, part_cnt, cycles, n_pass, n_fail;
  int          err [1:6];
  logic [31:0] iofs, dofs, res_idx;
  string       names [1:6] = '{"reset fetch and strobes", "add sub lui auipc results",
                               "branches and jumps", "load extension",
                               "byte and half stores", "halt freeze"};

  rv_core_top uut (.clk(clk), .rst_n(rst_n), .imem_data(imem_data), .dmem_rdata(dmem_rdata),
                   .imem_addr(imem_addr), .dmem_req(dmem_req), .halted(halted));

  always #4 clk = ~clk;

  assign iofs       = (imem_addr - `RV_RESET_PC) >> 2;
  assign imem_data  = imem[iofs[7:0]];
  assign dofs       = dmem_req.addr - DBASE;
  assign res_idx    = (dmem_req.addr - RES_BASE) >> 2;  // wraps high below the area
  assign dmem_rdata = dmem_req.rd ? {dmem[dofs[9:0] + 3], dmem[dofs[9:0] + 2],
                                     dmem[dofs[9:0] + 1], dmem[dofs[9:0]]}
                                  : 'x;  // data only on a read strobe

  function automatic logic [31:0] i_type(input logic [31:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
    return {imm[11:0], rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] s_type(input logic [31:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b010_0011};
  endfunction

  function automatic logic [31:0] b_type(input logic [31:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b110_0011};
  endfunction

  function automatic logic [31:0] u_type(input logic [31:0] imm, input logic [4:0] rd,
                                         input logic [6:0] op);
    return {imm[19:0], rd, op};
  endfunction

  function automatic logic [31:0] j_type(input logic [31:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b110_1111};
  endfunction

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b011_0011};
  endfunction

  // preload pattern, every address bit mixes in
  function automatic logic [7:0] fill_byte(input logic [31:0] a);
    return (a[7:0] * 8'h4b) ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'hc3;
  endfunction

  function automatic logic [31:0] word_at(input logic [31:0] a);
    return {fill_byte(a + 3), fill_byte(a + 2), fill_byte(a + 1), fill_byte(a)};
  endfunction

  task automatic emit(input logic [31:0] word);
    imem[pi] = word;
    pi++;
  endtask

  // sw to the next result slot, value it must carry
  task automatic store_result(input logic [4:0] rs, input logic [31:0] value);
    emit(s_type(32'h100 + 4 * n_res, rs, 5'd1, 3'b010));
    expect_tbl[n_res] = value;
    res_owner[n_res]  = section;
    n_res++;
  endtask

  task automatic load_const(input logic [4:0] rd, input logic [31:0] v);
    emit(u_type((v + 32'h800) >> 12, rd, 7'h37));  // lui rounded for the addi sign
    emit(i_type(v, rd, 3'b000, rd, 7'h13));
  endtask

  task automatic poison_store();
    emit(s_type(32'h0fc, 5'd20, 5'd1, 3'b010));
  endtask

  // a wrong turn either way lands on the poison store
  task automatic branch_case(input logic [2:0] f3, input logic [4:0] rs1,
                             input logic [4:0] rs2, input bit taken);
    emit(b_type(8, rs2, rs1, f3));
    if (!taken) emit(j_type(8, 5'd0));
    poison_store();
  endtask

  `include "tb_rv_program.svh"

  always @(posedge clk) begin
    if (rst_n && dmem_req.wr) begin
      for (int l = 0; l < 4; l++)
        if (dmem_req.wmask[l]) dmem[dofs[9:0] + l] <= dmem_req.wdata[8 * l +: 8];
      if (res_idx < n_res) seen[res_idx] <= 1'b1;
      if (dmem_req.wmask != 4'hf) part_cnt <= part_cnt + 1;
    end
  end

  reset_quiet: assert property (@(posedge clk)
      !rst_n |=> imem_addr == `RV_RESET_PC && !dmem_req.rd && !dmem_req.wr)
    else begin
      $display("FAIL t=%0t: fetch address or strobe wrong in reset", $time);
      err[1]++;
    end

  result_match: assert property (@(posedge clk) disable iff (!rst_n)
      dmem_req.wr && res_idx < n_res |->
        dmem_req.wmask == 4'hf && dmem_req.wdata == expect_tbl[res_idx])
    else begin
      $display("FAIL t=%0t: result %0d stored %h, expected %h", $time, $sampled(res_idx),
               $sampled(dmem_req.wdata), expect_tbl[$sampled(res_idx)]);
      err[res_owner[$sampled(res_idx)]]++;
    end

  no_poison: assert property (@(posedge clk) disable iff (!rst_n)
      dmem_req.wr |-> dmem_req.wdata != POISON)
    else begin
      $display("FAIL t=%0t: wrong path store at pc %h", $time, $sampled(imem_addr));
      err[3]++;
    end

  lane_rule: assert property (@(posedge clk) disable iff (!rst_n)
      dmem_req.wr && dmem_req.wmask != 4'hf |->
        part_cnt < 6 && dmem_req.wmask == lane_mask[part_cnt] &&
        (dmem_req.wmask inside {4'b0011, 4'b1100} ?
           dmem_req.wdata[31:16] == dmem_req.wdata[15:0] :
           dmem_req.wdata == {4{dmem_req.wdata[7:0]}}))
    else begin
      $display("FAIL t=%0t: partial store mask %b data %h", $time, $sampled(dmem_req.wmask),
               $sampled(dmem_req.wdata));
      err[5]++;
    end

  halt_frozen: assert property (@(posedge clk) disable iff (!rst_n)
      halted |-> !dmem_req.rd && !dmem_req.wr ##1 $stable(imem_addr))
    else begin
      $display("FAIL t=%0t: core active while halted", $time);
      err[6]++;
    end

  initial begin
    clk   = 1'b0;
    rst_n = 1'b0;
    for (int a = 0; a < 1024; a++) dmem[a] = fill_byte(DBASE + a);
    imem[0] = s_type(32'h0, 5'd0, 5'd0, 3'b010);  // sw under the reset pc, must not strobe
    repeat (3) @(posedge clk);
    #1;
    build_program();
    rst_n = 1'b1;
    cycles = 0;
    while (!halted && cycles < 2000) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (!halted) begin
      $display("core never halted within 2000 cycles");
      err[6]++;
    end
    imem[iofs[7:0]] = i_type(0, 5'd1, 3'b010, 5'd16, 7'h03);  // lw under the parked pc
    repeat (10) @(posedge clk);  // sit in halt for a while
    #1;
    for (int i = 0; i < n_res; i++) begin
      if (!seen[i]) begin
        $display("result word %0d was never stored", i);
        err[res_owner[i]]++;
      end
    end
    if (part_cnt != 6) begin
      $display("saw %0d byte or half stores instead of 6", part_cnt);
      err[5]++;
    end
    for (int b = 1; b <= 6; b++) begin
      $display("%-28s %s", names[b], (err[b] == 0) ? "ok" : "failed");
      if (err[b] == 0)
        n_pass++;
      else
        n_fail++;
    end
    $display("behaviors passed: %0d, failed: %0d", n_pass, n_fail);
    if (n_fail == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
+incdir+logic
+incdir+dv
logic/rv_isa_pkg.sv
logic/rv_core_pkg.sv
logic/rv_decoder.sv
logic/rv_regfile.sv
logic/rv_execute.sv
logic/rv_lsu.sv
logic/rv_core_top.sv
dv/tb_rv_core.sv

// File: Bender.yml
package:
  name: rv_core

export_include_dirs:
  - logic

sources:
  - files:
      - logic/rv_isa_pkg.sv
      - logic/rv_core_pkg.sv
      - logic/rv_decoder.sv
      - logic/rv_regfile.sv
      - logic/rv_execute.sv
      - logic/rv_lsu.sv
      - logic/rv_core_top.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/tb_rv_core.sv
